//--- sim/dispatch_patterns.txt
// one hex word per line, header first: program length, replay count, tasks per pass,
// configs per pass; then program words, expected task payloads, expected {num_fv, wb}
0000000a
00000002
00000006
00000002
// program, loaded from address 0
40001259  // cfg max_replay 2, num_fv 25, weights_boundary 9
80012015  // task vertex 0012, edges 005, bank 1
80abcfff  // task vertex 0abc, edges 3ff, bank 3
8ffff000  // task vertex ffff, edges 000, bank 0
12345678  // nop
400017f3  // cfg max_replay 2, num_fv 7f, weights_boundary 3
b1234556  // task with reserved bits set, vertex 1234, edges 155, bank 2
88000801  // task vertex 8000, edges 200, bank 1
80001006  // task vertex 0001, edges 001, bank 2
c0000000  // end of pass
// expected payloads in issue order, one pass
00012015
00abcfff
0ffff000
01234556
08000801
00001006
// expected num_fv and weights_boundary per config word
00000259
000007f3

//--- vlog.f
+incdir+include
rtl/dp_cfg_pkg.sv
rtl/dp_task_pkg.sv
rtl/imem_sram.sv
rtl/imem_fetch_cntl.sv
rtl/cmd_fifo.sv
rtl/cmd_decoder.sv
rtl/task_rs.sv
rtl/dp_dispatch_top.sv
sim/tb_dp_dispatch.sv

//--- Makefile
SIM      := verilator
TOP      := tb_dp_dispatch
FILELIST := vlog.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
PATTERNS := sim/dispatch_patterns.txt

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

# exit status comes from the search for the pass line
run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) | tee /dev/stderr | grep -x 'TEST PASS' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_dp_dispatch.sv
`timescale 1ns/1ps

module tb_dp_dispatch;

    import dp_cfg_pkg::*;
    import dp_task_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int PAT_WORDS    = 64;
    localparam int PROG_BASE    = 4;    // four header words come before the program
    localparam int TAIL_CYCLES  = 20;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic                  load_en;
    logic [imem_aw-1:0]    load_addr;
    logic [cmd_w-1:0]      load_data;
    logic [num_pe-1:0]     pe_idle;
    logic [num_pe-1:0]     bank_busy;
    pe_task_t [num_pe-1:0] pe_task;
    layer_cfg_t            layer_cfg;
    logic                  stream_begin;
    logic                  task_complete;

    logic [31:0]       pat [PAT_WORDS];
    int                prog_len;
    int                num_replay;
    int                tasks_per_pass;
    int                cfgs_per_pass;
    int                total_tasks;
    int                exp_base;
    int                cfg_base;
    logic              loaded;
    int                tasks_seen;
    int                cfgs_seen;
    int                task_errs;
    int                cfg_errs;
    int                iter_errs;
    int                misc_errs;
    logic [num_pe-1:0] pe_got;      // PEs that held valid in the last sampled cycle
    logic [num_pe-1:0] prev_idle;
    logic [num_pe-1:0] prev_busy;
    logic              complete_seen;
    int unsigned       busy_left [num_pe];

    dp_dispatch_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .pe_idle       (pe_idle),
        .bank_busy     (bank_busy),
        .pe_task       (pe_task),
        .layer_cfg     (layer_cfg),
        .stream_begin  (stream_begin),
        .task_complete (task_complete)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_task(input string name, input task_t got, input task_t exp_val);
        if (got !== exp_val) begin
            task_errs++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp_val);
        end
    endtask

    task automatic check_cfg(input string name, input layer_cfg_t got, input layer_cfg_t exp_val);
        if (got !== exp_val) begin
            cfg_errs++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp_val);
        end
    endtask

    task automatic check_iter(input string name, input logic [replay_w-1:0] got,
                              input logic [replay_w-1:0] exp_val);
        if (got !== exp_val) begin
            iter_errs++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp_val);
        end
    endtask

    task automatic report_fault(input string what);
        misc_errs++;
        $display("at time %0t: %s", $time, what);
    endtask

    task automatic report_counts();
        $display("errors: task=%0d cfg=%0d iter=%0d other=%0d",
                 task_errs, cfg_errs, iter_errs, misc_errs);
    endtask

    // config words repeat once per pass and replay_iter is the pass number
    function automatic layer_cfg_t expected_cfg(input int idx);
        layer_cfg_t c;
        logic [31:0] w;
        w = pat[cfg_base + idx % cfgs_per_pass];
        c.replay_iter = replay_w'(idx / cfgs_per_pass);
        {c.num_fv, c.weights_boundary} = w[fv_w+wb_w-1:0];
        return c;
    endfunction

    task automatic watch_issues();
        int    pass_no;
        task_t exp_pay;
        pe_got = '0;
        for (int p = 0; p < num_pe; p++) begin
            if (pe_task[p].valid === 1'b1) begin
                pe_got[p] = 1'b1;
                if (!prev_idle[p] || prev_busy[p]) begin
                    report_fault($sformatf("task went to PE %0d while it or its bank was busy", p));
                end
                if (tasks_seen >= total_tasks) begin
                    report_fault($sformatf("extra task %h on PE %0d", pe_task[p].payload, p));
                end else begin
                    pass_no = tasks_seen / tasks_per_pass;
                    exp_pay = pat[exp_base + tasks_seen % tasks_per_pass][$bits(task_t)-1:0];
                    check_task($sformatf("pe_task[%0d].payload", p), pe_task[p].payload, exp_pay);
                    if (tasks_seen % tasks_per_pass == 0) begin
                        check_iter("layer_cfg.replay_iter", layer_cfg.replay_iter,
                                   replay_w'(pass_no));
                    end
                    tasks_seen++;
                end
            end
        end
    endtask

    // outputs are sampled mid-cycle while inputs change just after the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            watch_issues();
            if (stream_begin === 1'b1) begin
                if (cfgs_seen >= cfgs_per_pass * (num_replay + 1)) begin
                    report_fault("stream_begin pulsed more often than the program has configs");
                end else begin
                    check_cfg("layer_cfg", layer_cfg, expected_cfg(cfgs_seen));
                end
                cfgs_seen++;
            end
            if (task_complete === 1'b1 && !complete_seen) begin
                complete_seen = 1'b1;
                if (tasks_seen != total_tasks) begin
                    report_fault($sformatf("task_complete rose after only %0d of %0d tasks",
                                           tasks_seen, total_tasks));
                end
            end
            prev_idle = pe_idle;
            prev_busy = bank_busy;
        end
    end

    // edge PE models plus a randomly toggling bank_busy per PE
    initial begin
        @(negedge reset);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            for (int p = 0; p < num_pe; p++) begin
                if (pe_got[p]) begin
                    busy_left[p] = $urandom_range(6, 1);
                end else if (busy_left[p] != 0) begin
                    busy_left[p]--;
                end
                pe_idle[p] = (busy_left[p] == 0);
                if ($urandom_range(3, 0) == 0) begin
                    bank_busy[p] = ~bank_busy[p];
                end
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (prog_len * (num_replay + 1) * 12 + 200) @(posedge clk);
        $display("timeout: task_complete never rose, %0d tasks seen", tasks_seen);
        report_counts();
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_reset_state();
        for (int p = 0; p < num_pe; p++) begin
            if (pe_task[p].valid !== 1'b0) begin
                report_fault($sformatf("pe_task[%0d].valid is not low after reset", p));
            end
        end
        if (stream_begin !== 1'b0 || task_complete !== 1'b0) begin
            report_fault("stream_begin or task_complete is not low after reset");
        end
        check_iter("layer_cfg.replay_iter", layer_cfg.replay_iter, '0);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            load_en   = 1'b1;
            load_addr = imem_aw'(i);
            load_data = pat[PROG_BASE + i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        load_en = 1'b0;
        start   = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        pe_idle   = '1;
        bank_busy = '0;
        pe_got    = '0;
        prev_idle = '1;
        prev_busy = '0;
        loaded    = 1'b0;
        complete_seen = 1'b0;
        tasks_seen = 0;
        cfgs_seen  = 0;
        task_errs  = 0;
        cfg_errs   = 0;
        iter_errs  = 0;
        misc_errs  = 0;
        for (int p = 0; p < num_pe; p++) begin
            busy_left[p] = 0;
        end
        void'($urandom(73700));
        $readmemh("sim/dispatch_patterns.txt", pat);
        prog_len       = pat[0];
        num_replay     = pat[1];
        tasks_per_pass = pat[2];
        cfgs_per_pass  = pat[3];
        exp_base       = PROG_BASE + prog_len;
        cfg_base       = exp_base + tasks_per_pass;
        total_tasks    = tasks_per_pass * (num_replay + 1);
        loaded         = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        load_program();

        while (task_complete !== 1'b1) begin
            @(negedge clk);
        end
        repeat (TAIL_CYCLES) @(negedge clk);   // room for a stray issue to show up
        if (tasks_seen != total_tasks) begin
            report_fault($sformatf("saw %0d tasks, expected %0d", tasks_seen, total_tasks));
        end
        if (cfgs_seen != cfgs_per_pass * (num_replay + 1)) begin
            report_fault($sformatf("saw %0d stream_begin pulses, expected %0d",
                                   cfgs_seen, cfgs_per_pass * (num_replay + 1)));
        end
        report_counts();
        if (task_errs + cfg_errs + iter_errs + misc_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/dp_dispatch_top.sv
`timescale 1ns/1ps
`include "dp_sizes.svh"

module dp_dispatch_top #(
    parameter int IMEM_DEPTH = `DP_IMEM_DEPTH,
    parameter int FIFO_DEPTH = `DP_FIFO_DEPTH,
    parameter int RS_DEPTH   = `DP_RS_DEPTH
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          start,
    input  logic                                          load_en,
    input  logic [dp_task_pkg::imem_aw-1:0]               load_addr,
    input  logic [dp_cfg_pkg::cmd_w-1:0]                  load_data,
    input  logic [dp_cfg_pkg::num_pe-1:0]                 pe_idle,
    input  logic [dp_cfg_pkg::num_pe-1:0]                 bank_busy,
    output dp_task_pkg::pe_task_t [dp_cfg_pkg::num_pe-1:0] pe_task,
    output dp_task_pkg::layer_cfg_t                       layer_cfg,
    output logic                                          stream_begin,
    output logic                                          task_complete
);

    import dp_cfg_pkg::*;
    import dp_task_pkg::*;

    imem_req_t                        imem_req;
    logic [cmd_w-1:0]                 imem_rdata;
    logic                             fifo_wr;
    logic [cmd_w-1:0]                 fifo_wdata;
    logic                             fifo_rd;
    cmd_word_t                        head_word;
    logic                             fifo_not_empty;
    logic                             fifo_full;
    logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_count;
    logic                             rs_push;
    task_t                            rs_task;
    logic                             rs_full;
    logic                             rs_empty;
    logic                             replay_restart;

    imem_sram #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
        .clk   (clk),
        .req   (imem_req),
        .rdata (imem_rdata)
    );

    imem_fetch_cntl #(.IMEM_DEPTH(IMEM_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) u_fetch (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .replay_restart (replay_restart),
        .fifo_full      (fifo_full),
        .fifo_count     (fifo_count),
        .imem_rdata     (imem_rdata),
        .imem_req       (imem_req),
        .fifo_wr        (fifo_wr),
        .fifo_wdata     (fifo_wdata)
    );

    // start flushes whatever a previous run left behind
    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .reset     (reset || start),
        .wr        (fifo_wr),
        .wdata     (fifo_wdata),
        .rd        (fifo_rd),
        .rdata     (head_word),
        .not_empty (fifo_not_empty),
        .full      (fifo_full),
        .count     (fifo_count)
    );

    cmd_decoder u_dec (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .head           (head_word),
        .not_empty      (fifo_not_empty),
        .rs_full        (rs_full),
        .rs_empty       (rs_empty),
        .pe_idle        (pe_idle),
        .fifo_rd        (fifo_rd),
        .rs_push        (rs_push),
        .rs_task        (rs_task),
        .replay_restart (replay_restart),
        .layer_cfg      (layer_cfg),
        .stream_begin   (stream_begin),
        .task_complete  (task_complete)
    );

    task_rs #(.RS_DEPTH(RS_DEPTH)) u_rs (
        .clk       (clk),
        .reset     (reset),
        .push      (rs_push),
        .task_in   (rs_task),
        .pe_idle   (pe_idle),
        .bank_busy (bank_busy),
        .pe_task   (pe_task),
        .rs_full   (rs_full),
        .rs_empty  (rs_empty)
    );

endmodule

//--- rtl/task_rs.sv
`timescale 1ns/1ps
`include "dp_sizes.svh"

module task_rs #(
    parameter int RS_DEPTH = `DP_RS_DEPTH
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          push,
    input  dp_task_pkg::task_t                            task_in,
    input  logic [dp_cfg_pkg::num_pe-1:0]                 pe_idle,
    input  logic [dp_cfg_pkg::num_pe-1:0]                 bank_busy,
    output dp_task_pkg::pe_task_t [dp_cfg_pkg::num_pe-1:0] pe_task,
    output logic                                          rs_full,
    output logic                                          rs_empty
);

    import dp_cfg_pkg::*;
    import dp_task_pkg::*;

    localparam int PTR_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    task_t             slots [RS_DEPTH];
    logic [PTR_W-1:0]  head_ptr;
    logic [PTR_W-1:0]  tail_ptr;
    logic [CNT_W-1:0]  count;
    logic [num_pe-1:0] eligible;
    logic [num_pe-1:0] grant;
    logic [num_pe-1:0] issue_vld;
    task_t             issue_pay;
    logic              do_push;
    logic              pop;

    // a PE that holds valid this cycle has not dropped its idle bit yet
    assign eligible = pe_idle & ~bank_busy & ~issue_vld;
    assign grant    = eligible & (~eligible + 1'b1);   // lowest set bit wins

    assign do_push = push && !rs_full;
    assign pop     = (count != '0) && (eligible != '0);

    assign rs_full  = (count == CNT_W'(RS_DEPTH));
    assign rs_empty = (count == '0) && (issue_vld == '0);

    always_comb begin
        for (int p = 0; p < num_pe; p++) begin
            pe_task[p].valid   = issue_vld[p];
            pe_task[p].payload = issue_pay;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            issue_vld <= '0;
        end else begin
            issue_vld <= pop ? grant : '0;
            if (do_push) begin
                tail_ptr <= (tail_ptr == PTR_W'(RS_DEPTH - 1)) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == PTR_W'(RS_DEPTH - 1)) ? '0 : head_ptr + 1'b1;
            end
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the oldest entry is handed out first and at most one leaves per cycle
    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[tail_ptr] <= task_in;
        end
        if (pop) begin
            issue_pay <= slots[head_ptr];
        end
    end

endmodule

//--- rtl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  dp_task_pkg::cmd_word_t          head,
    input  logic                            not_empty,
    input  logic                            rs_full,
    input  logic                            rs_empty,
    input  logic [dp_cfg_pkg::num_pe-1:0]   pe_idle,
    output logic                            fifo_rd,
    output logic                            rs_push,
    output dp_task_pkg::task_t              rs_task,
    output logic                            replay_restart,
    output dp_task_pkg::layer_cfg_t         layer_cfg,
    output logic                            stream_begin,
    output logic                            task_complete
);

    import dp_cfg_pkg::*;
    import dp_task_pkg::*;

    opcode_t             op;
    logic                draining;     // high once the final END is taken and the PEs are finishing
    logic [replay_w-1:0] max_replay;
    logic [replay_w-1:0] replay_iter;
    logic [fv_w-1:0]     num_fv;
    logic [wb_w-1:0]     weights_boundary;

    assign op = head.cfg_view.opcode;

    // a task at the head waits in the FIFO while the station is full
    assign fifo_rd = not_empty && !draining && !((op == OP_TASK) && rs_full);
    assign rs_push = fifo_rd && (op == OP_TASK);

    assign rs_task = '{vertex_id:  head.task_view.vertex_id,
                       edge_count: head.task_view.edge_count,
                       bank_sel:   head.task_view.bank_sel};

    assign layer_cfg = '{replay_iter:      replay_iter,
                         num_fv:           num_fv,
                         weights_boundary: weights_boundary};

    always_ff @(posedge clk) begin
        if (reset || start) begin
            draining       <= 1'b0;
            task_complete  <= 1'b0;
            stream_begin   <= 1'b0;
            replay_restart <= 1'b0;
            replay_iter    <= '0;
            max_replay     <= '0;
        end else begin
            stream_begin   <= fifo_rd && (op == OP_CFG);
            replay_restart <= 1'b0;
            if (fifo_rd && (op == OP_CFG)) begin
                max_replay <= head.cfg_view.max_replay;
            end
            if (fifo_rd && (op == OP_END)) begin
                if (replay_iter < max_replay) begin
                    replay_iter    <= replay_iter + 1'b1;
                    replay_restart <= 1'b1;
                end else begin
                    draining <= 1'b1;
                end
            end
            // stays high until the next start
            if (draining && rs_empty && (&pe_idle)) begin
                task_complete <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd && (op == OP_CFG)) begin
            num_fv           <= head.cfg_view.num_fv;
            weights_boundary <= head.cfg_view.weights_boundary;
        end
    end

endmodule

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps
`include "dp_sizes.svh"

module cmd_fifo #(
    parameter int FIFO_DEPTH = `DP_FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr,
    input  logic [dp_cfg_pkg::cmd_w-1:0]    wdata,
    input  logic                            rd,
    output logic [dp_cfg_pkg::cmd_w-1:0]    rdata,
    output logic                            not_empty,
    output logic                            full,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

    import dp_cfg_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [cmd_w-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign do_wr     = wr && !full;
    assign do_rd     = rd && not_empty;
    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign rdata     = mem[rd_ptr];   // head word is shown before it is read

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

//--- rtl/imem_fetch_cntl.sv
`timescale 1ns/1ps
`include "dp_sizes.svh"

module imem_fetch_cntl #(
    parameter int IMEM_DEPTH = `DP_IMEM_DEPTH,
    parameter int FIFO_DEPTH = `DP_FIFO_DEPTH
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  logic                                load_en,
    input  logic [dp_task_pkg::imem_aw-1:0]     load_addr,
    input  logic [dp_cfg_pkg::cmd_w-1:0]        load_data,
    input  logic                                replay_restart,
    input  logic                                fifo_full,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_count,
    input  logic [dp_cfg_pkg::cmd_w-1:0]        imem_rdata,
    output dp_task_pkg::imem_req_t              imem_req,
    output logic                                fifo_wr,
    output logic [dp_cfg_pkg::cmd_w-1:0]        fifo_wdata
);

    import dp_cfg_pkg::*;
    import dp_task_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic               running;
    logic [imem_aw-1:0] pc;
    logic               rd_vld;      // the word read last cycle is on imem_rdata
    logic               host_wr;
    logic               rd_issue;
    logic               end_hit;
    logic [1:0]         in_flight;
    logic [CNT_W:0]     committed;
    cmd_word_t          rword;

    assign host_wr = load_en && !running;   // host owns the port only while idle

    assign imem_req = '{wen: host_wr, addr: host_wr ? load_addr : pc, data: load_data};

    assign rword   = imem_rdata;
    assign end_hit = rd_vld && (rword.cfg_view.opcode == OP_END);

    // words already read but not yet counted by the FIFO
    assign in_flight = {1'b0, rd_vld} + {1'b0, fifo_wr};
    assign committed = {1'b0, fifo_count} + (CNT_W + 1)'(in_flight);

    // no read goes out in the cycle END returns, so nothing past END is fetched
    assign rd_issue = running && !end_hit && !fifo_full &&
                      (committed < (CNT_W + 1)'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= '0;
            rd_vld  <= 1'b0;
            fifo_wr <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            pc      <= '0;
            rd_vld  <= 1'b0;
            fifo_wr <= 1'b0;
        end else begin
            rd_vld  <= rd_issue;
            fifo_wr <= rd_vld;
            if (replay_restart) begin
                running <= 1'b1;   // next pass starts over from address 0
                pc      <= '0;
            end else begin
                if (end_hit) begin
                    running <= 1'b0;
                end
                if (rd_issue) begin
                    pc <= (pc == imem_aw'(IMEM_DEPTH - 1)) ? '0 : pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            fifo_wdata <= imem_rdata;
        end
    end

endmodule

//--- rtl/imem_sram.sv
`timescale 1ns/1ps
`include "dp_sizes.svh"

module imem_sram #(
    parameter int IMEM_DEPTH = `DP_IMEM_DEPTH
) (
    input  logic                         clk,
    input  dp_task_pkg::imem_req_t       req,
    output logic [dp_cfg_pkg::cmd_w-1:0] rdata
);

    import dp_cfg_pkg::*;

    logic [cmd_w-1:0] mem [IMEM_DEPTH];

    // a write cycle on the single port returns the old word on rdata
    always_ff @(posedge clk) begin
        if (req.wen) begin
            mem[req.addr] <= req.data;
        end
        rdata <= mem[req.addr];
    end

endmodule

//--- rtl/dp_task_pkg.sv
`include "dp_sizes.svh"

package dp_task_pkg;

    import dp_cfg_pkg::*;

    localparam int unsigned imem_aw = $clog2(`DP_IMEM_DEPTH);

    // reserved bits sit right after the opcode in both views
    localparam int unsigned cfg_pad_w  = cmd_w - 2 - replay_w - fv_w - wb_w;
    localparam int unsigned task_pad_w = cmd_w - 2 - vid_w - edge_w - bank_w;

    typedef struct packed {
        opcode_t               opcode;
        logic [cfg_pad_w-1:0]  rsvd;
        logic [replay_w-1:0]   max_replay;
        logic [fv_w-1:0]       num_fv;
        logic [wb_w-1:0]       weights_boundary;
    } cfg_view_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [task_pad_w-1:0] rsvd;
        logic [vid_w-1:0]      vertex_id;
        logic [edge_w-1:0]     edge_count;
        logic [bank_w-1:0]     bank_sel;
    } task_view_t;

    // one command word is read as config or as task depending on its opcode
    typedef union packed {
        cfg_view_t  cfg_view;
        task_view_t task_view;
    } cmd_word_t;

    typedef struct packed {
        logic [vid_w-1:0]  vertex_id;
        logic [edge_w-1:0] edge_count;
        logic [bank_w-1:0] bank_sel;
    } task_t;

    typedef struct packed {
        logic  valid;
        task_t payload;
    } pe_task_t;

    typedef struct packed {
        logic               wen;
        logic [imem_aw-1:0] addr;
        logic [cmd_w-1:0]   data;
    } imem_req_t;

    typedef struct packed {
        logic [replay_w-1:0] replay_iter;
        logic [fv_w-1:0]     num_fv;
        logic [wb_w-1:0]     weights_boundary;
    } layer_cfg_t;

endpackage

//--- rtl/dp_cfg_pkg.sv
`include "dp_sizes.svh"

package dp_cfg_pkg;

    localparam int unsigned num_pe = `DP_NUM_PE;
    localparam int unsigned cmd_w  = `DP_CMD_W;

    // layer configuration fields carried by a CFG command
    localparam int unsigned replay_w = 3;
    localparam int unsigned fv_w     = 7;
    localparam int unsigned wb_w     = 4;

    // task fields carried by a TASK command
    localparam int unsigned vid_w  = 16;
    localparam int unsigned edge_w = 10;
    localparam int unsigned bank_w = 2;   // one of four memory banks

    // top two bits of every command word
    typedef enum logic [1:0] {
        OP_NOP  = 2'b00,
        OP_CFG  = 2'b01,
        OP_TASK = 2'b10,
        OP_END  = 2'b11   // closes one pass of the program
    } opcode_t;

endpackage

//--- include/dp_sizes.svh
`ifndef DP_SIZES_SVH
`define DP_SIZES_SVH

// number of edge PEs fed by the dispatcher
`define DP_NUM_PE      4

`define DP_CMD_W       32

// the instruction SRAM depth also sets the load address width
`define DP_IMEM_DEPTH  64

`define DP_FIFO_DEPTH  8   // command FIFO between fetch and decode

`define DP_RS_DEPTH    4   // reservation station entries

`endif
